// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv32i_pipe_tb
FLIST     ?= rv32i_pipe.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/100ps

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
HDRS := $(wildcard rtl/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	$(BIN) | tee $(LOG)

check: run
	@if grep -q "sim failed" $(LOG) || ! grep -q "sim passed" $(LOG); then \
		echo "FAIL"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/clock_gen.sv
`default_nettype none
`timescale 1ns/100ps

module clock_gen (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;   // 20 ns period
   end

   // Held for five rising edges
   initial begin
      reset = 1'b1;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

`default_nettype wire

// File: bench/rv32i_pipe_tb.sv
`default_nettype none
`timescale 1ns/100ps
`include "rv32i_macros.svh"

module rv32i_pipe_tb;

   localparam int          reset_timeout = 20;
   localparam int          run_timeout = 600;
   localparam logic [31:0] lfsr_seed = 32'hb522_3751;
   localparam logic [6:0]  op_imm = 7'b0010011;
   localparam logic [6:0]  op_load = 7'b0000011;

   logic                      clk;
   logic                      reset;
   logic                      run;
   logic                      imem_we;
   logic [`RV32I_IMEM_AW-1:0] imem_addr;
   logic [31:0]               imem_data;
   logic                      retire_ready;
   logic                      retire_valid;
   rv32i_pkg::retire_t        retire;

   logic [31:0]        prog_q[$];
   rv32i_pkg::retire_t expected_q[$];
   logic [31:0]        lfsr_state;
   int                 checks;
   int                 errors;
   int                 timeouts;

   clock_gen u_clock_gen (.clk(clk), .reset(reset));

   rv32i_pipe UUT (
      .clk(clk), .reset(reset), .run_i(run), .imem_we_i(imem_we), .imem_addr_i(imem_addr),
      .imem_data_i(imem_data), .retire_ready_i(retire_ready), .retire_valid_o(retire_valid),
      .retire_o(retire));

   function automatic logic [31:0] reg_word(input int funct7, input int funct3, input int rd,
                                            input int rs1, input int rs2);
      reg_word = {funct7[6:0], rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], 7'b0110011};
   endfunction

   function automatic logic [31:0] imm_word(input logic [6:0] opc, input int funct3,
                                            input int rd, input int rs1, input int imm);
      imm_word = {imm[11:0], rs1[4:0], funct3[2:0], rd[4:0], opc};
   endfunction

   function automatic logic [31:0] store_word(input int rs2, input int rs1, input int imm);
      store_word = {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] branch_word(input int funct3, input int rs1, input int rs2,
                                               input int imm);
      branch_word = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], funct3[2:0], imm[4:1], imm[11],
                     7'b1100011};
   endfunction

   function automatic logic [31:0] jal_word(input int rd, input int imm);
      jal_word = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
   endfunction

   function automatic logic [31:0] lui_word(input int rd, input int imm);
      lui_word = {imm[19:0], rd[4:0], 7'b0110111};
   endfunction

   // Galois form, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] state);
      lfsr_step = (state >> 1) ^ (state[0] ? 32'h8020_0003 : 32'h0);
   endfunction

   function automatic void append_insn(input logic [31:0] word);
      prog_q.push_back(word);
   endfunction

   function automatic void expect_retire(input logic [31:0] pc, input logic [4:0] rd,
                                         input logic we, input logic [31:0] value);
      rv32i_pkg::retire_t row;
      row.pc = pc;
      row.rd = rd;
      row.we = we;
      row.value = value;
      expected_q.push_back(row);
   endfunction

   task automatic build_tables();
      append_insn(imm_word(op_imm, 0, 1, 0, 5));        // addi x1, x0, 5
      append_insn(imm_word(op_imm, 0, 2, 0, -3));       // addi x2, x0, -3
      append_insn(reg_word(0, 0, 3, 1, 2));             // add x3, x1, x2
      append_insn(reg_word(32, 0, 4, 1, 2));            // sub x4, x1, x2
      append_insn(reg_word(0, 7, 5, 3, 4));             // and x5, x3, x4
      append_insn(reg_word(0, 6, 6, 1, 4));             // or x6, x1, x4
      append_insn(reg_word(0, 4, 7, 6, 2));             // xor x7, x6, x2
      append_insn(reg_word(0, 2, 8, 2, 1));             // slt x8, x2, x1
      append_insn(reg_word(0, 1, 9, 1, 3));             // sll x9, x1, x3
      append_insn(reg_word(0, 5, 10, 7, 3));            // srl x10, x7, x3
      append_insn(imm_word(op_imm, 7, 11, 7, 'hff));    // andi x11, x7, 0xff
      append_insn(imm_word(op_imm, 6, 12, 1, 'h100));   // ori x12, x1, 0x100
      append_insn(imm_word(op_imm, 4, 13, 1, -1));      // xori x13, x1, -1
      append_insn(imm_word(op_imm, 2, 14, 2, -2));      // slti x14, x2, -2
      append_insn(lui_word(15, 'h12345));
      append_insn(imm_word(op_imm, 0, 15, 15, 'h678));  // addi x15, x15, 0x678
      append_insn(store_word(15, 0, 8));                // sw x15, 8(x0)
      append_insn(imm_word(op_load, 2, 16, 0, 8));      // lw x16, 8(x0)
      append_insn(imm_word(op_imm, 0, 17, 16, 1));      // Load result used at once
      append_insn(reg_word(0, 0, 18, 16, 17));          // add x18, x16, x17
      append_insn(branch_word(0, 1, 8, 12));            // beq x1, x8, not taken
      append_insn(branch_word(1, 1, 8, 12));            // bne x1, x8, taken
      append_insn(imm_word(op_imm, 0, 19, 0, 99));
      append_insn(imm_word(op_imm, 0, 19, 0, 98));
      append_insn(branch_word(0, 14, 8, 12));           // beq x14, x8, taken
      append_insn(imm_word(op_imm, 0, 20, 0, 77));
      append_insn(imm_word(op_imm, 0, 20, 0, 76));
      append_insn(jal_word(21, 12));                    // jal x21, +12
      append_insn(imm_word(op_imm, 0, 22, 0, 55));
      append_insn(imm_word(op_imm, 0, 22, 0, 54));
      append_insn(imm_word(op_imm, 0, 23, 21, 4));      // addi x23, x21, 4
      append_insn(jal_word(0, 0));                      // Parking loop

      expect_retire(32'h00, 5'd1, 1'b1, 32'h0000_0005);
      expect_retire(32'h04, 5'd2, 1'b1, 32'hffff_fffd);
      expect_retire(32'h08, 5'd3, 1'b1, 32'h0000_0002);
      expect_retire(32'h0c, 5'd4, 1'b1, 32'h0000_0008);
      expect_retire(32'h10, 5'd5, 1'b1, 32'h0000_0000);
      expect_retire(32'h14, 5'd6, 1'b1, 32'h0000_000d);
      expect_retire(32'h18, 5'd7, 1'b1, 32'hffff_fff0);
      expect_retire(32'h1c, 5'd8, 1'b1, 32'h0000_0001);
      expect_retire(32'h20, 5'd9, 1'b1, 32'h0000_0014);
      expect_retire(32'h24, 5'd10, 1'b1, 32'h3fff_fffc);
      expect_retire(32'h28, 5'd11, 1'b1, 32'h0000_00f0);
      expect_retire(32'h2c, 5'd12, 1'b1, 32'h0000_0105);
      expect_retire(32'h30, 5'd13, 1'b1, 32'hffff_fffa);
      expect_retire(32'h34, 5'd14, 1'b1, 32'h0000_0001);
      expect_retire(32'h38, 5'd15, 1'b1, 32'h1234_5000);
      expect_retire(32'h3c, 5'd15, 1'b1, 32'h1234_5678);
      expect_retire(32'h40, 5'd0, 1'b0, 32'h0);   // Store writes no register
      expect_retire(32'h44, 5'd16, 1'b1, 32'h1234_5678);
      expect_retire(32'h48, 5'd17, 1'b1, 32'h1234_5679);
      expect_retire(32'h4c, 5'd18, 1'b1, 32'h2468_acf1);
      expect_retire(32'h50, 5'd0, 1'b0, 32'h0);
      expect_retire(32'h54, 5'd0, 1'b0, 32'h0);
      expect_retire(32'h60, 5'd0, 1'b0, 32'h0);
      expect_retire(32'h6c, 5'd21, 1'b1, 32'h0000_0070);
      expect_retire(32'h78, 5'd23, 1'b1, 32'h0000_0074);
      expect_retire(32'h7c, 5'd0, 1'b0, 32'h0);
   endtask

   task automatic wait_reset_release();
      int n;
      n = 0;
      while (reset !== 1'b0 && n < reset_timeout) begin
         @(posedge clk);
         n++;
      end
      if (reset !== 1'b0) begin
         $display("Reset was still asserted after %0d cycles", reset_timeout);
         timeouts++;
      end
   endtask

   task automatic check_idle();
      if (retire_valid !== 1'b0) begin
         $display("Error: retire_valid_o = %h before run_i, expected 0", retire_valid);
         errors++;
      end
   endtask

   task automatic load_program();
      for (int i = 0; i < 4; i++) begin
         @(posedge clk);
         check_idle();
      end
      for (int i = 0; i < prog_q.size(); i++) begin
         @(posedge clk);
         check_idle();
         imem_we <= 1'b1;
         imem_addr <= i[`RV32I_IMEM_AW-1:0];
         imem_data <= prog_q[i];
      end
      @(posedge clk);
      check_idle();
      imem_we <= 1'b0;
      run <= 1'b1;
   endtask

   task automatic check_retire(input int row);
      rv32i_pkg::retire_t exp_row;
      exp_row = expected_q[row];
      checks++;
      if (retire.pc !== exp_row.pc) begin
         $display("Error: retire_o.pc = %h, expected %h (row %0d)", retire.pc, exp_row.pc, row);
         errors++;
      end
      if (retire.we !== exp_row.we) begin
         $display("Error: retire_o.we = %h, expected %h (row %0d)", retire.we, exp_row.we, row);
         errors++;
      end
      if (exp_row.we && retire.rd !== exp_row.rd) begin
         $display("Error: retire_o.rd = %h, expected %h (row %0d)", retire.rd, exp_row.rd, row);
         errors++;
      end
      if (exp_row.we && retire.value !== exp_row.value) begin
         $display("Error: retire_o.value = %h, expected %h (row %0d)",
                  retire.value, exp_row.value, row);
         errors++;
      end
   endtask

   // Samples before the edge updates, then draws the next ready bit
   task automatic run_program();
      int   cycles;
      int   row;
      logic first_seen;
      cycles = 0;
      row = 0;
      first_seen = 1'b0;
      while (row < expected_q.size() && cycles < run_timeout) begin
         @(posedge clk);
         cycles++;
         if (retire_valid === 1'b1 && !first_seen) begin
            first_seen = 1'b1;
            if (cycles != 4) begin
               $display("First retirement came %0d cycles after run, not 4", cycles);
               errors++;
            end
         end
         if (retire_valid === 1'b1 && retire_ready === 1'b1) begin
            check_retire(row);
            row++;
         end
         lfsr_state = lfsr_step(lfsr_state);
         retire_ready <= lfsr_state[0];
      end
      if (row < expected_q.size()) begin
         $display("Only %0d of %0d retirements seen within %0d cycles",
                  row, expected_q.size(), run_timeout);
         timeouts++;
      end
   endtask

   task automatic report_result();
      $display("%0d retirements checked, %0d errors, %0d timeouts", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   endtask

   initial begin
      run = 1'b0;
      imem_we = 1'b0;
      imem_addr = '0;
      imem_data = '0;
      retire_ready = 1'b0;
      lfsr_state = lfsr_seed;
      checks = 0;
      errors = 0;
      timeouts = 0;
      build_tables();
      wait_reset_release();
      if (timeouts == 0) begin
         load_program();
         run_program();
      end
      report_result();
   end

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`default_nettype none
`timescale 1ns/100ps

module decode_stage (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          advance_i,
   input  wire                          flush_i,
   input  wire rv32i_pkg::fetch_pkt_t   fetch_i,
   output logic [4:0]                   rs1_o,
   output logic [4:0]                   rs2_o,
   input  wire [31:0]                   rdata1_i,
   input  wire [31:0]                   rdata2_i,
   output rv32i_pkg::decode_pkt_t       decode_o
);

   rv32i_pkg::insn_u       insn;
   rv32i_pkg::decode_pkt_t decode_d;
   logic [31:0]            imm_i, imm_s, imm_b, imm_j, imm_u;
   logic                   writes_rd;

   // Shared by OP and OP-IMM, alt selects SUB
   function automatic rv32i_pkg::alu_op_t alu_sel(input logic [2:0] funct3, input logic alt);
      case (funct3)
         3'b000:  alu_sel = alt ? rv32i_pkg::alu_sub : rv32i_pkg::alu_add;
         3'b001:  alu_sel = rv32i_pkg::alu_sll;
         3'b010:  alu_sel = rv32i_pkg::alu_slt;
         3'b100:  alu_sel = rv32i_pkg::alu_xor;
         3'b101:  alu_sel = rv32i_pkg::alu_srl;
         3'b110:  alu_sel = rv32i_pkg::alu_or;
         3'b111:  alu_sel = rv32i_pkg::alu_and;
         default: alu_sel = rv32i_pkg::alu_add;
      endcase
   endfunction

   assign insn = fetch_i.insn;
   assign rs1_o = insn.r_view.rs1;
   assign rs2_o = insn.r_view.rs2;

   assign imm_i = {{20{insn[31]}}, insn[31:20]};
   assign imm_s = {{20{insn.s_view.imm_hi[6]}}, insn.s_view.imm_hi, insn.s_view.imm_lo};
   assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
   assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
   assign imm_u = {insn[31:12], 12'd0};

   always_comb begin
      decode_d = '0;
      writes_rd = 1'b0;
      decode_d.alu_op = rv32i_pkg::alu_add;
      decode_d.use_imm = 1'b1;
      decode_d.imm = imm_i;
      case (rv32i_pkg::opcode_t'(insn.r_view.opcode))
         rv32i_pkg::opc_op: begin
            decode_d.alu_op = alu_sel(insn.r_view.funct3, insn.r_view.funct7[5]);
            decode_d.use_imm = 1'b0;
            writes_rd = 1'b1;
         end
         rv32i_pkg::opc_op_imm: begin
            decode_d.alu_op = alu_sel(insn.r_view.funct3, 1'b0);
            writes_rd = 1'b1;
         end
         rv32i_pkg::opc_lui: begin
            decode_d.alu_op = rv32i_pkg::alu_pass_b;
            decode_d.imm = imm_u;
            writes_rd = 1'b1;
         end
         rv32i_pkg::opc_load: begin
            decode_d.is_load = 1'b1;
            writes_rd = 1'b1;
         end
         rv32i_pkg::opc_store: begin
            decode_d.is_store = 1'b1;
            decode_d.imm = imm_s;
         end
         rv32i_pkg::opc_branch: begin
            decode_d.is_branch = 1'b1;
            decode_d.branch_ne = insn.r_view.funct3[0];   // BNE
            decode_d.imm = imm_b;
         end
         rv32i_pkg::opc_jal: begin
            decode_d.is_jal = 1'b1;
            decode_d.imm = imm_j;
            writes_rd = 1'b1;
         end
         default: ;   // Retires with nothing written
      endcase
      decode_d.valid = fetch_i.valid && !flush_i;
      decode_d.pc = fetch_i.pc;
      decode_d.rd = insn.r_view.rd;
      decode_d.rs1 = insn.r_view.rs1;
      decode_d.rs2 = insn.r_view.rs2;
      decode_d.op_a = rdata1_i;
      decode_d.op_b = rdata2_i;
      decode_d.reg_write = writes_rd && (insn.r_view.rd != 5'd0);
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         decode_o.valid <= 1'b0;
      end else if (advance_i) begin
         decode_o <= decode_d;
      end
   end

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`default_nettype none
`timescale 1ns/100ps

module execute_stage (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          advance_i,
   input  wire rv32i_pkg::decode_pkt_t  decode_i,
   input  wire rv32i_pkg::wb_fwd_t      wb_i,
   output rv32i_pkg::redirect_t         redirect_o,
   output rv32i_pkg::exec_pkt_t         exec_o
);

   logic [31:0] op_a, op_b, alu_b, alu_result;
   logic        fwd_a, fwd_b, take;
   rv32i_pkg::exec_pkt_t exec_d;

   // Only the retiring instruction can be newer than the register read
   assign fwd_a = wb_i.we && wb_i.rd != 5'd0 && wb_i.rd == decode_i.rs1;
   assign fwd_b = wb_i.we && wb_i.rd != 5'd0 && wb_i.rd == decode_i.rs2;
   assign op_a = fwd_a ? wb_i.value : decode_i.op_a;
   assign op_b = fwd_b ? wb_i.value : decode_i.op_b;
   assign alu_b = decode_i.use_imm ? decode_i.imm : op_b;

   always_comb begin
      case (decode_i.alu_op)
         rv32i_pkg::alu_add:    alu_result = op_a + alu_b;
         rv32i_pkg::alu_sub:    alu_result = op_a - alu_b;
         rv32i_pkg::alu_and:    alu_result = op_a & alu_b;
         rv32i_pkg::alu_or:     alu_result = op_a | alu_b;
         rv32i_pkg::alu_xor:    alu_result = op_a ^ alu_b;
         rv32i_pkg::alu_slt:    alu_result = {31'd0, $signed(op_a) < $signed(alu_b)};
         rv32i_pkg::alu_sll:    alu_result = op_a << alu_b[4:0];
         rv32i_pkg::alu_srl:    alu_result = op_a >> alu_b[4:0];
         rv32i_pkg::alu_pass_b: alu_result = alu_b;
         default:               alu_result = 32'd0;
      endcase
   end

   // BEQ and BNE share the compare
   assign take = decode_i.valid &&
                 (decode_i.is_jal || (decode_i.is_branch && ((op_a == op_b) ^ decode_i.branch_ne)));

   assign redirect_o.taken = take && advance_i;
   assign redirect_o.target = decode_i.pc + decode_i.imm;

   always_comb begin
      exec_d.valid = decode_i.valid;
      exec_d.pc = decode_i.pc;
      exec_d.rd = decode_i.rd;
      exec_d.alu_result = decode_i.is_jal ? decode_i.pc + 32'd4 : alu_result;   // Link
      exec_d.store_data = op_b;
      exec_d.reg_write = decode_i.reg_write;
      exec_d.is_load = decode_i.is_load;
      exec_d.is_store = decode_i.is_store;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         exec_o.valid <= 1'b0;
      end else if (advance_i) begin
         exec_o <= exec_d;
      end
   end

endmodule

`default_nettype wire

// File: rtl/fetch_stage.sv
`default_nettype none
`timescale 1ns/100ps
`include "rv32i_macros.svh"

module fetch_stage (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          run_i,
   input  wire                          advance_i,
   input  wire                          imem_we_i,
   input  wire [`RV32I_IMEM_AW-1:0]     imem_addr_i,
   input  wire [31:0]                   imem_data_i,
   input  wire rv32i_pkg::redirect_t    redirect_i,
   output rv32i_pkg::fetch_pkt_t        fetch_o
);

   logic [31:0] imem [`RV32I_IMEM_WORDS];
   logic [31:0] pc_q;

   always_ff @(posedge clk) begin
      if (imem_we_i) begin
         imem[imem_addr_i] <= imem_data_i;   // Loaded while halted
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc_q <= `RV32I_RESET_PC;
         fetch_o.valid <= 1'b0;
      end else if (advance_i) begin
         if (redirect_i.taken) begin
            pc_q <= redirect_i.target;
            fetch_o.valid <= 1'b0;   // Younger slot squashed
         end else begin
            fetch_o.valid <= run_i;
            if (run_i) begin
               fetch_o.pc <= pc_q;
               fetch_o.insn <= imem[pc_q[`RV32I_IMEM_AW+1:2]];
               pc_q <= pc_q + 32'd4;
            end
         end
      end
   end

   // Redirect targets from execute must land on words
   pc_aligned_a: assert property (@(posedge clk) disable iff (reset) pc_q[1:0] == 2'b00)
      else $error("misaligned pc %h", pc_q);

endmodule

`default_nettype wire

// File: rtl/mem_wb_stage.sv
`default_nettype none
`timescale 1ns/100ps
`include "rv32i_macros.svh"

module mem_wb_stage (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          retire_ready_i,
   input  wire rv32i_pkg::exec_pkt_t    exec_i,
   output logic                         advance_o,
   output rv32i_pkg::wb_fwd_t           wb_o,
   output logic                         retire_valid_o,
   output rv32i_pkg::retire_t           retire_o
);

   logic [31:0] dmem [`RV32I_DMEM_WORDS];
   logic [31:0] load_data;
   logic [31:0] wb_value;
   logic        accept;

   assign retire_valid_o = exec_i.valid;
   assign accept = exec_i.valid && retire_ready_i;
   assign advance_o = !exec_i.valid || retire_ready_i;   // Whole pipe freezes otherwise

   // Async read so a load result forwards in its retire cycle
   assign load_data = dmem[exec_i.alu_result[`RV32I_DMEM_AW+1:2]];

   always_ff @(posedge clk) begin
      if (accept && exec_i.is_store) begin
         dmem[exec_i.alu_result[`RV32I_DMEM_AW+1:2]] <= exec_i.store_data;
      end
   end

   assign wb_value = exec_i.is_load ? load_data : exec_i.alu_result;

   assign wb_o = '{we: accept && exec_i.reg_write, rd: exec_i.rd, value: wb_value};

   assign retire_o = '{
      pc:    exec_i.pc,
      rd:    exec_i.rd,
      we:    exec_i.reg_write,
      value: wb_value
   };

   // Upstream stages must hold the packet while the sink stalls
   retire_hold_a: assert property (@(posedge clk) disable iff (reset)
      retire_valid_o && !retire_ready_i |=> retire_valid_o && $stable(retire_o))
      else $error("retire_o changed under back-pressure");

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`default_nettype none
`timescale 1ns/100ps

module reg_file (
   input  wire                       clk,
   input  wire                       reset,
   input  wire [4:0]                 rs1_i,
   input  wire [4:0]                 rs2_i,
   input  wire rv32i_pkg::wb_fwd_t   wb_i,
   output logic [31:0]               rdata1_o,
   output logic [31:0]               rdata2_o
);

   logic [31:0] regs [32];   // Entry 0 backs x0

   always_ff @(posedge clk) begin
      if (reset) begin
         regs[0] <= 32'd0;
      end else if (wb_i.we && wb_i.rd != 5'd0) begin
         regs[wb_i.rd] <= wb_i.value;
      end
   end

   // Same-cycle write shows up on the read ports
   assign rdata1_o = (wb_i.we && wb_i.rd == rs1_i) ? wb_i.value : regs[rs1_i];
   assign rdata2_o = (wb_i.we && wb_i.rd == rs2_i) ? wb_i.value : regs[rs2_i];

   // x0 stays zero only while writeback never names it
   x0_zero_a: assert property (@(posedge clk) disable iff (reset)
      (rs1_i == 5'd0 |-> rdata1_o == 32'd0) and (rs2_i == 5'd0 |-> rdata2_o == 32'd0));

endmodule

`default_nettype wire

// File: rtl/rv32i_macros.svh
`ifndef RV32I_MACROS_SVH
`define RV32I_MACROS_SVH

// Memory depths in 32-bit words
`define RV32I_IMEM_WORDS 64
`define RV32I_DMEM_WORDS 64

// Word index widths
`define RV32I_IMEM_AW ($clog2(`RV32I_IMEM_WORDS))
`define RV32I_DMEM_AW ($clog2(`RV32I_DMEM_WORDS))

`define RV32I_RESET_PC 32'h0000_0000

`endif

// File: rtl/rv32i_pipe.sv
`default_nettype none
`timescale 1ns/100ps
`include "rv32i_macros.svh"

module rv32i_pipe (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          run_i,
   input  wire                          imem_we_i,
   input  wire [`RV32I_IMEM_AW-1:0]     imem_addr_i,
   input  wire [31:0]                   imem_data_i,
   input  wire                          retire_ready_i,
   output logic                         retire_valid_o,
   output rv32i_pkg::retire_t           retire_o
);

   logic                   advance;
   logic [4:0]             rs1, rs2;
   logic [31:0]            rdata1, rdata2;
   rv32i_pkg::redirect_t   redirect;
   rv32i_pkg::fetch_pkt_t  fetch_pkt;
   rv32i_pkg::decode_pkt_t decode_pkt;
   rv32i_pkg::exec_pkt_t   exec_pkt;
   rv32i_pkg::wb_fwd_t     wb;

   fetch_stage u_fetch (
      .clk(clk), .reset(reset), .run_i(run_i), .advance_i(advance),
      .imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i), .imem_data_i(imem_data_i),
      .redirect_i(redirect), .fetch_o(fetch_pkt));

   decode_stage u_decode (
      .clk(clk), .reset(reset), .advance_i(advance), .flush_i(redirect.taken),
      .fetch_i(fetch_pkt), .rs1_o(rs1), .rs2_o(rs2),
      .rdata1_i(rdata1), .rdata2_i(rdata2), .decode_o(decode_pkt));

   reg_file u_reg_file (
      .clk(clk), .reset(reset), .rs1_i(rs1), .rs2_i(rs2), .wb_i(wb),
      .rdata1_o(rdata1), .rdata2_o(rdata2));

   execute_stage u_execute (
      .clk(clk), .reset(reset), .advance_i(advance), .decode_i(decode_pkt),
      .wb_i(wb), .redirect_o(redirect), .exec_o(exec_pkt));

   mem_wb_stage u_mem_wb (
      .clk(clk), .reset(reset), .retire_ready_i(retire_ready_i), .exec_i(exec_pkt),
      .advance_o(advance), .wb_o(wb), .retire_valid_o(retire_valid_o), .retire_o(retire_o));

endmodule

`default_nettype wire

// File: rtl/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

   // Major opcodes of the supported subset
   typedef enum logic [6:0] {
      opc_op     = 7'b0110011,
      opc_op_imm = 7'b0010011,
      opc_lui    = 7'b0110111,
      opc_load   = 7'b0000011,
      opc_store  = 7'b0100011,
      opc_branch = 7'b1100011,
      opc_jal    = 7'b1101111
   } opcode_t;

   typedef enum logic [3:0] {
      alu_add, alu_sub, alu_and, alu_or, alu_xor,
      alu_slt, alu_sll, alu_srl, alu_pass_b
   } alu_op_t;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_view_t;

   // Store layout, offset split around rs fields
   typedef struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
   } s_view_t;

   typedef union packed {
      r_view_t r_view;
      s_view_t s_view;
   } insn_u;

   typedef struct packed {
      logic        valid;
      logic [31:0] pc;
      insn_u       insn;
   } fetch_pkt_t;

   typedef struct packed {
      logic        valid;
      logic [31:0] pc;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [31:0] op_a;
      logic [31:0] op_b;
      logic [31:0] imm;
      alu_op_t     alu_op;
      logic        use_imm;
      logic        reg_write;
      logic        is_load;
      logic        is_store;
      logic        is_branch;
      logic        branch_ne;
      logic        is_jal;
   } decode_pkt_t;

   typedef struct packed {
      logic        valid;
      logic [31:0] pc;
      logic [4:0]  rd;
      logic [31:0] alu_result;   // Also the data memory address
      logic [31:0] store_data;
      logic        reg_write;
      logic        is_load;
      logic        is_store;
   } exec_pkt_t;

   typedef struct packed {
      logic        we;
      logic [4:0]  rd;
      logic [31:0] value;
   } wb_fwd_t;

   typedef struct packed {
      logic        taken;
      logic [31:0] target;
   } redirect_t;

   typedef struct packed {
      logic [31:0] pc;
      logic [4:0]  rd;
      logic        we;
      logic [31:0] value;
   } retire_t;

endpackage

`default_nettype wire

// File: rv32i_pipe.f
+incdir+rtl
rtl/rv32i_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/reg_file.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/rv32i_pipe.sv
bench/clock_gen.sv
bench/rv32i_pipe_tb.sv
